//--- hw/rv_pkg.sv
package rv_pkg;

    typedef logic [63:0] t_xlen_word;
    typedef logic [63:0] t_addr;
    typedef logic [31:0] t_instr_word;
    typedef logic [4:0]  t_reg_idx;
    typedef logic [2:0]  t_funct3;
    typedef logic [6:0]  t_funct7;
    typedef logic [6:0]  t_opcode;

    // major opcodes handled by decode
    localparam t_opcode OPC_LOAD      = 7'b0000011;
    localparam t_opcode OPC_OP_IMM    = 7'b0010011;
    localparam t_opcode OPC_AUIPC     = 7'b0010111;
    localparam t_opcode OPC_OP_IMM_32 = 7'b0011011;
    localparam t_opcode OPC_STORE     = 7'b0100011;
    localparam t_opcode OPC_OP        = 7'b0110011;
    localparam t_opcode OPC_LUI       = 7'b0110111;
    localparam t_opcode OPC_OP_32     = 7'b0111011;
    localparam t_opcode OPC_BRANCH    = 7'b1100011;
    localparam t_opcode OPC_JALR      = 7'b1100111;
    localparam t_opcode OPC_JAL       = 7'b1101111;
    localparam t_opcode OPC_SYSTEM    = 7'b1110011;

    typedef enum logic [2:0] {
        FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J, FMT_NONE
    } t_instr_fmt;

    typedef enum logic [1:0] {
        OP_REG, OP_IMM, OP_ZERO, OP_INVD
    } t_optype;

    typedef enum logic [1:0] {
        SZ_4B, SZ_8B
    } t_opsize;

    typedef struct packed {
        t_reg_idx opreg;
        t_optype  optype;
        t_opsize  opsize;
    } t_operand;

    typedef enum logic [4:0] {
        U_ADD, U_SUB, U_SLL, U_SLT, U_SLTU, U_XOR, U_SRL, U_SRA, U_OR, U_AND,
        U_LOAD, U_STORE, U_BRANCH, U_LUI, U_AUIPC, U_JAL, U_JALR, U_EBREAK,
        U_ILLEGAL
    } t_uop;

    // R-type view of the raw word, other formats reuse the same slices
    typedef struct packed {
        t_funct7  funct7;
        t_reg_idx rs2;
        t_reg_idx rs1;
        t_funct3  funct3;
        t_reg_idx rd;
        t_opcode  opcode;
    } t_instr_fields;

    typedef struct packed {
        t_addr       pc;
        t_instr_word instr;
    } t_instr_pkt;

    typedef struct packed {
        t_uop       uop;
        t_instr_fmt ifmt;
        t_funct3    funct3;
        t_funct7    funct7;
        t_operand   dst;
        t_operand   src1;
        t_operand   src2;
        t_xlen_word imm64;
        t_addr      pc;
    } t_uinstr;

    function automatic t_instr_fmt get_instr_format(input t_opcode opcode);
        t_instr_fmt fmt;
        case (opcode)
            OPC_OP, OPC_OP_32:
                fmt = FMT_R;
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_LOAD, OPC_JALR, OPC_SYSTEM:
                fmt = FMT_I;
            OPC_STORE:
                fmt = FMT_S;
            OPC_BRANCH:
                fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:
                fmt = FMT_U;
            OPC_JAL:
                fmt = FMT_J;
            default:
                fmt = FMT_NONE;
        endcase
        return fmt;
    endfunction

endpackage

//--- hw/imm_gen.sv
module imm_gen (
    input  rv_pkg::t_instr_word instr,
    output rv_pkg::t_xlen_word  imm64
);

    rv_pkg::t_instr_fmt ifmt;

    assign ifmt = rv_pkg::get_instr_format(instr[6:0]);

    always_comb begin
        case (ifmt)
            rv_pkg::FMT_I: begin
                imm64 = {{52{instr[31]}}, instr[31:20]};
            end
            rv_pkg::FMT_S: begin
                imm64 = {{52{instr[31]}}, instr[31:25], instr[11:7]};
            end
            rv_pkg::FMT_B: begin
                // 13 bit offset, lsb always zero
                imm64 = {{51{instr[31]}}, instr[31], instr[7], instr[30:25],
                         instr[11:8], 1'b0};
            end
            rv_pkg::FMT_U: begin
                imm64 = {{32{instr[31]}}, instr[31:12], 12'b0};
            end
            rv_pkg::FMT_J: begin
                // 21 bit offset, lsb always zero
                imm64 = {{43{instr[31]}}, instr[31], instr[19:12], instr[20],
                         instr[30:21], 1'b0};
            end
            default: begin
                // R format and unknown opcodes
                imm64 = '0;
            end
        endcase
    end

endmodule

//--- hw/uop_map.sv
module uop_map (
    input  rv_pkg::t_instr_word instr,
    output rv_pkg::t_uop        uop,
    output rv_pkg::t_opsize     opsize
);

    rv_pkg::t_instr_fields fields;
    logic                  is_reg_op;
    logic                  is_word_op;

    assign fields     = rv_pkg::t_instr_fields'(instr);
    assign is_reg_op  = (fields.opcode == rv_pkg::OPC_OP) |
                        (fields.opcode == rv_pkg::OPC_OP_32);
    assign is_word_op = (fields.opcode == rv_pkg::OPC_OP_32) |
                        (fields.opcode == rv_pkg::OPC_OP_IMM_32);

    // W-suffix ops work on the low word
    assign opsize = is_word_op ? rv_pkg::SZ_4B : rv_pkg::SZ_8B;

    always_comb begin
        uop = rv_pkg::U_ILLEGAL;
        case (fields.opcode)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_32, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP_IMM_32: begin
                case (fields.funct3)
                    3'd0: uop = (is_reg_op & fields.funct7[5]) ? rv_pkg::U_SUB : rv_pkg::U_ADD;
                    3'd1: uop = rv_pkg::U_SLL;
                    3'd2: uop = rv_pkg::U_SLT;
                    3'd3: uop = rv_pkg::U_SLTU;
                    3'd4: uop = rv_pkg::U_XOR;
                    // arithmetic shift on both reg and imm forms
                    3'd5: uop = fields.funct7[5] ? rv_pkg::U_SRA : rv_pkg::U_SRL;
                    3'd6: uop = rv_pkg::U_OR;
                    default: uop = rv_pkg::U_AND;
                endcase
            end
            rv_pkg::OPC_LOAD: begin
                uop = rv_pkg::U_LOAD;
            end
            rv_pkg::OPC_STORE: begin
                uop = rv_pkg::U_STORE;
            end
            rv_pkg::OPC_BRANCH: begin
                uop = rv_pkg::U_BRANCH;
            end
            rv_pkg::OPC_LUI: begin
                uop = rv_pkg::U_LUI;
            end
            rv_pkg::OPC_AUIPC: begin
                uop = rv_pkg::U_AUIPC;
            end
            rv_pkg::OPC_JAL: begin
                uop = rv_pkg::U_JAL;
            end
            rv_pkg::OPC_JALR: begin
                uop = rv_pkg::U_JALR;
            end
            rv_pkg::OPC_SYSTEM: begin
                // only ebreak, imm field == 1
                if (instr[31:20] == 12'd1) begin
                    uop = rv_pkg::U_EBREAK;
                end
            end
            default: begin
                uop = rv_pkg::U_ILLEGAL;
            end
        endcase
    end

endmodule

//--- hw/decode.sv
module decode (
    input  logic               valid_in,
    input  rv_pkg::t_instr_pkt instr_in,
    output rv_pkg::t_uinstr    uinstr_de0,
    output logic               push_de0
);

    rv_pkg::t_instr_fields fields_de0;
    rv_pkg::t_instr_fmt    ifmt_de0;
    rv_pkg::t_uop          uop_de0;
    rv_pkg::t_opsize       opsize_de0;
    rv_pkg::t_xlen_word    imm64_de0;

    assign fields_de0 = rv_pkg::t_instr_fields'(instr_in.instr);
    assign ifmt_de0   = rv_pkg::get_instr_format(fields_de0.opcode);

    imm_gen u_imm_gen (
        .instr (instr_in.instr),
        .imm64 (imm64_de0)
    );

    uop_map u_uop_map (
        .instr  (instr_in.instr),
        .uop    (uop_de0),
        .opsize (opsize_de0)
    );

    // flush handling lives in the queue
    assign push_de0 = valid_in;

    always_comb begin
        uinstr_de0        = '0;
        uinstr_de0.uop    = uop_de0;
        uinstr_de0.ifmt   = ifmt_de0;
        uinstr_de0.imm64  = imm64_de0;
        uinstr_de0.pc     = instr_in.pc;
        uinstr_de0.dst    = '{opreg: '0, optype: rv_pkg::OP_INVD, opsize: opsize_de0};
        uinstr_de0.src1   = '{opreg: '0, optype: rv_pkg::OP_INVD, opsize: opsize_de0};
        uinstr_de0.src2   = '{opreg: '0, optype: rv_pkg::OP_INVD, opsize: opsize_de0};

        case (ifmt_de0)
            rv_pkg::FMT_R: begin
                uinstr_de0.funct3 = fields_de0.funct3;
                uinstr_de0.funct7 = fields_de0.funct7;
                uinstr_de0.dst.opreg   = fields_de0.rd;
                uinstr_de0.dst.optype  = rv_pkg::OP_REG;
                uinstr_de0.src1.opreg  = fields_de0.rs1;
                uinstr_de0.src1.optype = rv_pkg::OP_REG;
                uinstr_de0.src2.opreg  = fields_de0.rs2;
                uinstr_de0.src2.optype = rv_pkg::OP_REG;
            end
            rv_pkg::FMT_I: begin
                // also jalr, loads and ebreak
                uinstr_de0.funct3 = fields_de0.funct3;
                uinstr_de0.dst.opreg   = fields_de0.rd;
                uinstr_de0.dst.optype  = rv_pkg::OP_REG;
                uinstr_de0.src1.opreg  = fields_de0.rs1;
                uinstr_de0.src1.optype = rv_pkg::OP_REG;
                uinstr_de0.src2.optype = rv_pkg::OP_IMM;
            end
            rv_pkg::FMT_S, rv_pkg::FMT_B: begin
                // no destination, compare or address and data sources
                uinstr_de0.funct3 = fields_de0.funct3;
                uinstr_de0.src1.opreg  = fields_de0.rs1;
                uinstr_de0.src1.optype = rv_pkg::OP_REG;
                uinstr_de0.src2.opreg  = fields_de0.rs2;
                uinstr_de0.src2.optype = rv_pkg::OP_REG;
            end
            rv_pkg::FMT_U, rv_pkg::FMT_J: begin
                uinstr_de0.dst.opreg   = fields_de0.rd;
                uinstr_de0.dst.optype  = rv_pkg::OP_REG;
            end
            default: begin
                // unknown opcode, operands stay invalid
                uinstr_de0.funct3 = '0;
            end
        endcase

        // x0 handling
        if (uinstr_de0.src1.optype == rv_pkg::OP_REG && uinstr_de0.src1.opreg == '0) begin
            uinstr_de0.src1.optype = rv_pkg::OP_ZERO;
        end
        if (uinstr_de0.src2.optype == rv_pkg::OP_REG && uinstr_de0.src2.opreg == '0) begin
            uinstr_de0.src2.optype = rv_pkg::OP_ZERO;
        end
        if (uinstr_de0.dst.optype == rv_pkg::OP_REG && uinstr_de0.dst.opreg == '0) begin
            uinstr_de0.dst.optype = rv_pkg::OP_INVD;
        end
    end

endmodule

//--- hw/uop_queue.sv
module uop_queue #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            push,
    input  rv_pkg::t_uinstr din,
    input  logic            flush,
    input  logic            pop_ready,
    output logic            valid_out,
    output rv_pkg::t_uinstr dout,
    output logic            full
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    rv_pkg::t_uinstr  entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             push_ok;
    logic             pop;

    // wrap for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == CNT_W'(QUEUE_DEPTH));
    assign push_ok = push & ~full & ~flush;
    assign pop     = ~empty & pop_ready & ~flush;

    assign valid_out = pop;
    assign dout      = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            entries[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push_ok) - CNT_W'(pop);
        end
    end

endmodule

//--- hw/decode_top.sv
module decode_top #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               valid_in,
    input  rv_pkg::t_instr_pkt instr_in,
    input  logic               br_mispred,
    input  logic               rename_ready,
    output logic               valid_out,
    output rv_pkg::t_uinstr    uinstr_out,
    output logic               queue_full
);

    rv_pkg::t_uinstr uinstr_de0;
    logic            push_de0;

    decode u_decode (
        .valid_in   (valid_in),
        .instr_in   (instr_in),
        .uinstr_de0 (uinstr_de0),
        .push_de0   (push_de0)
    );

    // DE1
    uop_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_uop_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (push_de0),
        .din       (uinstr_de0),
        .flush     (br_mispred),
        .pop_ready (rename_ready),
        .valid_out (valid_out),
        .dout      (uinstr_out),
        .full      (queue_full)
    );

endmodule

//--- test/tb_decode.sv
module tb_decode;

    localparam int QUEUE_DEPTH    = 2;
    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTR + 100;

    logic               clk;
    logic               reset;
    logic               valid_in;
    rv_pkg::t_instr_pkt instr_in;
    logic               br_mispred;
    logic               rename_ready;
    logic               valid_out;
    rv_pkg::t_uinstr    uinstr_out;
    logic               queue_full;

    integer             seed = 32'hc337;
    logic [31:0]        rnd;
    int                 sent;
    int                 cycles;
    int                 flush_wait;
    rv_pkg::t_addr      pc_next;
    rv_pkg::t_uinstr    exp_q[$];
    rv_pkg::t_uinstr    expected_uinstr;
    logic               exp_valid;

    decode_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (
        .clk          (clk),
        .reset        (reset),
        .valid_in     (valid_in),
        .instr_in     (instr_in),
        .br_mispred   (br_mispred),
        .rename_ready (rename_ready),
        .valid_out    (valid_out),
        .uinstr_out   (uinstr_out),
        .queue_full   (queue_full)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic [63:0] sign_extend(input logic [63:0] value, input int bits);
        logic [63:0] mask;
        mask = ~64'd0 << bits;
        if (value[bits-1]) begin
            return value | mask;
        end
        return value & ~mask;
    endfunction

    function automatic rv_pkg::t_uop alu_uop(input logic [2:0] f3, input logic alt,
                                             input logic is_reg);
        case (f3)
            3'd0: return (is_reg && alt) ? rv_pkg::U_SUB : rv_pkg::U_ADD;
            3'd1: return rv_pkg::U_SLL;
            3'd2: return rv_pkg::U_SLT;
            3'd3: return rv_pkg::U_SLTU;
            3'd4: return rv_pkg::U_XOR;
            3'd5: return alt ? rv_pkg::U_SRA : rv_pkg::U_SRL;
            3'd6: return rv_pkg::U_OR;
            default: return rv_pkg::U_AND;
        endcase
    endfunction

    function automatic rv_pkg::t_operand src_operand(input logic [4:0] r, input logic used,
                                                     input rv_pkg::t_opsize sz);
        rv_pkg::t_operand op;
        op.opsize = sz;
        op.opreg  = used ? r : 5'd0;
        if (!used) begin
            op.optype = rv_pkg::OP_INVD;
        end else begin
            op.optype = (r == 5'd0) ? rv_pkg::OP_ZERO : rv_pkg::OP_REG;
        end
        return op;
    endfunction

    function automatic rv_pkg::t_operand dst_operand(input logic [4:0] r, input logic used,
                                                     input rv_pkg::t_opsize sz);
        rv_pkg::t_operand op;
        op.opsize = sz;
        op.opreg  = used ? r : 5'd0;
        op.optype = (used && r != 5'd0) ? rv_pkg::OP_REG : rv_pkg::OP_INVD;
        return op;
    endfunction

    function automatic rv_pkg::t_uinstr ref_decode(input rv_pkg::t_instr_pkt pkt);
        rv_pkg::t_uinstr u;
        rv_pkg::t_opsize sz;
        logic [31:0]     w;
        logic [6:0]      opc;
        logic            use_rd;
        logic            use_rs1;
        logic            use_rs2;
        logic            imm_src;
        w       = pkt.instr;
        opc     = w[6:0];
        u       = '0;
        u.pc    = pkt.pc;
        u.uop   = rv_pkg::U_ILLEGAL;
        u.ifmt  = rv_pkg::FMT_NONE;
        sz      = (opc == rv_pkg::OPC_OP_32 || opc == rv_pkg::OPC_OP_IMM_32) ?
                  rv_pkg::SZ_4B : rv_pkg::SZ_8B;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        imm_src = 1'b0;
        case (opc)
            rv_pkg::OPC_OP, rv_pkg::OPC_OP_32: begin
                u.ifmt   = rv_pkg::FMT_R;
                u.uop    = alu_uop(w[14:12], w[30], 1'b1);
                u.funct7 = w[31:25];
                {use_rd, use_rs1, use_rs2} = 3'b111;
            end
            rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP_IMM_32, rv_pkg::OPC_LOAD,
            rv_pkg::OPC_JALR, rv_pkg::OPC_SYSTEM: begin
                u.ifmt  = rv_pkg::FMT_I;
                u.imm64 = sign_extend({52'd0, w[31:20]}, 12);
                {use_rd, use_rs1, imm_src} = 3'b111;
                if (opc == rv_pkg::OPC_LOAD) begin
                    u.uop = rv_pkg::U_LOAD;
                end else if (opc == rv_pkg::OPC_JALR) begin
                    u.uop = rv_pkg::U_JALR;
                end else if (opc == rv_pkg::OPC_SYSTEM) begin
                    u.uop = (w[31:20] == 12'd1) ? rv_pkg::U_EBREAK : rv_pkg::U_ILLEGAL;
                end else begin
                    u.uop = alu_uop(w[14:12], w[30], 1'b0);
                end
            end
            rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH: begin
                {use_rs1, use_rs2} = 2'b11;
                if (opc == rv_pkg::OPC_STORE) begin
                    u.ifmt  = rv_pkg::FMT_S;
                    u.uop   = rv_pkg::U_STORE;
                    u.imm64 = sign_extend({52'd0, w[31:25], w[11:7]}, 12);
                end else begin
                    u.ifmt  = rv_pkg::FMT_B;
                    u.uop   = rv_pkg::U_BRANCH;
                    u.imm64 = sign_extend({51'd0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);
                end
            end
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: begin
                u.ifmt  = rv_pkg::FMT_U;
                u.uop   = (opc == rv_pkg::OPC_LUI) ? rv_pkg::U_LUI : rv_pkg::U_AUIPC;
                u.imm64 = sign_extend({32'd0, w[31:12], 12'd0}, 32);
                use_rd  = 1'b1;
            end
            rv_pkg::OPC_JAL: begin
                u.ifmt  = rv_pkg::FMT_J;
                u.uop   = rv_pkg::U_JAL;
                u.imm64 = sign_extend({43'd0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);
                use_rd  = 1'b1;
            end
            default: begin
            end
        endcase
        // funct3 only where the format carries it
        if (u.ifmt == rv_pkg::FMT_R || u.ifmt == rv_pkg::FMT_I ||
            u.ifmt == rv_pkg::FMT_S || u.ifmt == rv_pkg::FMT_B) begin
            u.funct3 = w[14:12];
        end
        u.dst  = dst_operand(w[11:7], use_rd, sz);
        u.src1 = src_operand(w[19:15], use_rs1, sz);
        u.src2 = src_operand(w[24:20], use_rs2, sz);
        if (imm_src) begin
            u.src2.optype = rv_pkg::OP_IMM;
        end
        return u;
    endfunction

    function automatic rv_pkg::t_instr_word random_instr();
        logic [31:0] r1;
        logic [31:0] w;
        logic [6:0]  opc;
        r1 = $random(seed);
        w  = $random(seed);
        case (r1[3:0])
            4'd0, 4'd12: opc = rv_pkg::OPC_OP;
            4'd1:        opc = rv_pkg::OPC_OP_32;
            4'd2, 4'd13: opc = rv_pkg::OPC_OP_IMM;
            4'd3:        opc = rv_pkg::OPC_OP_IMM_32;
            4'd4:        opc = rv_pkg::OPC_LOAD;
            4'd5:        opc = rv_pkg::OPC_STORE;
            4'd6:        opc = rv_pkg::OPC_BRANCH;
            4'd7:        opc = rv_pkg::OPC_LUI;
            4'd8:        opc = rv_pkg::OPC_AUIPC;
            4'd9:        opc = rv_pkg::OPC_JAL;
            4'd10:       opc = rv_pkg::OPC_JALR;
            4'd11:       opc = rv_pkg::OPC_SYSTEM;
            // low bits 00 is never a covered opcode
            default:     opc = {w[6:2], 2'b00};
        endcase
        w[6:0] = opc;
        if ((opc == rv_pkg::OPC_OP || opc == rv_pkg::OPC_OP_32 || opc == rv_pkg::OPC_OP_IMM ||
             opc == rv_pkg::OPC_OP_IMM_32) && r1[5:4] != 2'd0) begin
            w[31:25] = {1'b0, r1[6], 5'd0};
        end
        // lean on x0 fairly often
        w[11:7]  = (r1[8:7] == 2'd0) ? 5'd0 : w[11:7];
        w[19:15] = (r1[10:9] == 2'd0) ? 5'd0 : w[19:15];
        w[24:20] = (r1[12:11] == 2'd0) ? 5'd0 : w[24:20];
        if (opc == rv_pkg::OPC_SYSTEM && r1[13]) begin
            w[31:7] = {12'd1, 13'd0};
        end
        return w;
    endfunction

    task automatic compare_uinstr(input rv_pkg::t_uinstr exp_u, input rv_pkg::t_uinstr act_u);
        check_value("uop", 64'(exp_u.uop), 64'(act_u.uop));
        check_value("ifmt", 64'(exp_u.ifmt), 64'(act_u.ifmt));
        check_value("funct3", 64'(exp_u.funct3), 64'(act_u.funct3));
        check_value("funct7", 64'(exp_u.funct7), 64'(act_u.funct7));
        check_value("dst", 64'(exp_u.dst), 64'(act_u.dst));
        check_value("src1", 64'(exp_u.src1), 64'(act_u.src1));
        check_value("src2", 64'(exp_u.src2), 64'(act_u.src2));
        check_value("imm64", exp_u.imm64, act_u.imm64);
        check_value("pc", exp_u.pc, act_u.pc);
    endtask

    // scoreboard sampled on the rising edge before the queue updates
    always @(posedge clk) begin
        if (!reset) begin
            check_value("queue_full", 64'(exp_q.size() == QUEUE_DEPTH), 64'(queue_full));
            exp_valid = (exp_q.size() != 0) && rename_ready && !br_mispred;
            check_value("valid_out", 64'(exp_valid), 64'(valid_out));
            if (br_mispred) begin
                exp_q.delete();
            end else begin
                if (valid_out) begin
                    expected_uinstr = exp_q.pop_front();
                    compare_uinstr(expected_uinstr, uinstr_out);
                end
                if (valid_in && !queue_full) begin
                    exp_q.push_back(ref_decode(instr_in));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    initial begin
        reset        = 1'b1;
        valid_in     = 1'b0;
        instr_in     = '0;
        br_mispred   = 1'b0;
        rename_ready = 1'b0;
        cycles       = 0;
        sent         = 0;
        flush_wait   = 200;
        pc_next      = 64'h0000_0000_8000_0000;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        while (sent < NUM_INSTR) begin
            @(negedge clk);
            rnd          = $random(seed);
            rename_ready = rnd[0];
            valid_in     = 1'b0;
            if (flush_wait == 0) begin
                br_mispred = 1'b1;
                flush_wait = 150 + int'(rnd[15:8]);
            end else begin
                br_mispred = 1'b0;
                flush_wait = flush_wait - 1;
            end
            if (!queue_full && rnd[1]) begin
                instr_in.pc    = pc_next;
                instr_in.instr = random_instr();
                valid_in       = 1'b1;
                pc_next        = pc_next + 64'd4;
                sent           = sent + 1;
            end
        end
        @(negedge clk);
        valid_in     = 1'b0;
        br_mispred   = 1'b0;
        rename_ready = 1'b1;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- all.f
hw/rv_pkg.sv
hw/imm_gen.sv
hw/uop_map.sv
hw/decode.sv
hw/uop_queue.sv
hw/decode_top.sv
test/tb_decode.sv

//--- run.sh
#!/bin/sh
# compile and run the decode testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_decode -f all.f -o sim_decode
./obj_dir/sim_decode
